//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_unit_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bus_pkg.sv
// types for the bus cycle sequencing
package bus_pkg;

    // controller state, one state per beat
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // waiting for req
        ST_BEAT0 = 2'd1,    // first beat, address as given
        ST_BEAT1 = 2'd2     // second beat of a long, address+2
    } state_e;

    // operation latched at the start of an access
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } op_e;

endpackage

//--- mem_addr_gen.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

// effective address register and bus address for each beat
module mem_addr_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  logic                        start,
    input  logic                        beat,     // move to upper half
    input  logic                        da2ea,
    input  mem_pkg::ea_sel_e            ea_sel,
    input  logic [`MEM_ADDR_W-1:0]      da,
    input  logic [`MEM_ADDR_W-1:0]      pc,
    input  logic [2*`MEM_DATA_W-1:0]    xsp,
    output logic [`MEM_ADDR_W-1:0]      ea,
    output logic [`MEM_ADDR_W-1:0]      bus_addr
);

    logic [`MEM_ADDR_W-1:0] nx_addr;    // address of the first beat

    always_comb begin
        case (ea_sel)
            mem_pkg::EA_DA: nx_addr = da;
            mem_pkg::EA_SP: nx_addr = xsp[`MEM_ADDR_W-1:0];   // upper xsp bits ignored
            mem_pkg::EA_EA: nx_addr = ea;
            default:        nx_addr = pc;                       // EA_PC, fetch
        endcase
    end

    // ea loads whenever microcode asks, busy or not
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ea <= '0;
        end else if (cen && da2ea) begin
            ea <= da;
        end
    end

    // bus_addr only moves at beat boundaries
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_addr <= '0;
        end else if (cen) begin
            if (start) begin
                bus_addr <= nx_addr;
            end else if (beat) begin
                bus_addr <= bus_addr + `MEM_ADDR_W'(2);   // next word, even
            end
        end
    end

endmodule

//--- mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// external bus geometry
`define MEM_ADDR_W 24         // byte address, 16M space
`define MEM_DATA_W 16         // one bus beat

// extra cycles added to every bus beat
// a beat lasts MEM_WAIT_STATES+1 enabled cycles
// range 0..7, the beat timer is 3 bits wide
`define MEM_WAIT_STATES 1

// register side values (md, mdata, xsp) are two beats wide
// i.e. 2*MEM_DATA_W = 32 bits
// long accesses are split low half first, address then address+2

// word and long addresses must be even
// byte accesses may use either lane
//   even address -> bus_dout[7:0]
//   odd address  -> bus_dout[15:8]
// byte writes drive the same byte on both lanes,
// memory picks its lane from the address

`endif

//--- mem_ctrl.sv
`timescale 1ns/100ps

// sequences the beats of one access
// strobes and busy are decoded straight from state/op flops
module mem_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    input  logic            req,
    input  logic            wr,
    input  mem_pkg::size_e  size,
    input  logic            beat_last,     // last cycle of current beat
    output logic            start,         // accepted request, this edge
    output logic            beat,          // beat0 -> beat1 this edge
    output logic            timer_run,
    output logic            capture,       // read data valid this edge
    output logic            bus_rd,
    output logic            bus_wr,
    output logic            busy
);

    bus_pkg::state_e state;
    bus_pkg::op_e    op;
    logic            long_q;               // second beat pending

    assign busy      = state != bus_pkg::ST_IDLE;
    assign bus_rd    = op == bus_pkg::OP_READ;
    assign bus_wr    = op == bus_pkg::OP_WRITE;
    assign timer_run = busy;               // timer only counts inside a beat

    // req ignored while busy or frozen
    assign start   = cen && req && !busy;
    assign beat    = cen && beat_last && long_q && state == bus_pkg::ST_BEAT0;
    assign capture = beat_last && bus_rd;  // sample bus_dout at beat end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= bus_pkg::ST_IDLE;
            op     <= bus_pkg::OP_NONE;
            long_q <= 1'b0;
        end else if (cen) begin
            case (state)
                bus_pkg::ST_IDLE: begin
                    if (start) begin
                        state  <= bus_pkg::ST_BEAT0;
                        op     <= wr ? bus_pkg::OP_WRITE : bus_pkg::OP_READ;
                        long_q <= mem_pkg::is_long(size);
                    end
                end
                bus_pkg::ST_BEAT0: begin
                    if (beat) begin
                        state <= bus_pkg::ST_BEAT1;    // upper half next
                    end else if (beat_last) begin
                        state <= bus_pkg::ST_IDLE;     // byte/word done
                        op    <= bus_pkg::OP_NONE;
                    end
                end
                bus_pkg::ST_BEAT1: begin
                    if (beat_last) begin
                        state  <= bus_pkg::ST_IDLE;
                        op     <= bus_pkg::OP_NONE;
                        long_q <= 1'b0;
                    end
                end
                default: begin
                    state <= bus_pkg::ST_IDLE;         // unused encoding
                    op    <= bus_pkg::OP_NONE;
                end
            endcase
        end
    end

endmodule

//--- mem_data_path.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

// write lane placement and read data assembly
module mem_data_path (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  logic                        start,
    input  logic                        beat,
    input  logic                        capture,
    input  mem_pkg::size_e              size,
    input  logic                        addr_lsb,   // bus_addr[0], held through the beat
    input  logic [2*`MEM_DATA_W-1:0]    md,
    input  logic [`MEM_DATA_W-1:0]      bus_dout,
    output logic [`MEM_DATA_W-1:0]      bus_din,
    output logic [2*`MEM_DATA_W-1:0]    mdata
);

    localparam int HW = `MEM_DATA_W / 2;    // lane width

    mem_pkg::size_e           size_q;
    logic                     second;       // in upper beat of a long
    logic                     final_beat;
    logic [`MEM_DATA_W-1:0]   md_hi;        // upper half for beat 1
    logic [`MEM_DATA_W-1:0]   low_q;        // first beat of a long read
    logic [HW-1:0]            rd_byte;

    // odd address reads the high lane
    assign rd_byte    = addr_lsb ? bus_dout[`MEM_DATA_W-1:HW] : bus_dout[HW-1:0];
    assign final_beat = !mem_pkg::is_long(size_q) || second;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_din <= '0;
            mdata   <= '0;
            size_q  <= mem_pkg::SZ_BYTE;
            second  <= 1'b0;
        end else if (cen) begin
            if (start) begin
                size_q  <= size;
                second  <= 1'b0;
                // bytes go on both lanes, memory picks by address
                bus_din <= mem_pkg::is_byte(size) ? {2{md[HW-1:0]}} : md[`MEM_DATA_W-1:0];
            end else if (beat) begin
                second  <= 1'b1;
                bus_din <= md_hi;
            end
            if (capture && final_beat) begin
                case (size_q)
                    mem_pkg::SZ_WORD: mdata <= {{`MEM_DATA_W{1'b0}}, bus_dout};
                    mem_pkg::SZ_LONG: mdata <= {bus_dout, low_q};   // little endian
                    default:          mdata <= {{(2*`MEM_DATA_W-HW){1'b0}}, rd_byte};
                endcase
            end
        end
    end

    // upper write half and low read half
    always_ff @(posedge clk) begin
        if (cen) begin
            if (start) md_hi <= md[2*`MEM_DATA_W-1:`MEM_DATA_W];
            if (capture && !final_beat) low_q <= bus_dout;
        end
    end

endmodule

//--- mem_pkg.sv
// types seen by the microcode side of the memory unit
package mem_pkg;

    // where the access address comes from
    typedef enum logic [1:0] {
        EA_DA = 2'd0,   // address from register unit
        EA_SP = 2'd1,   // stack pointer, low 24 bits of xsp
        EA_EA = 2'd2,   // latched effective address
        EA_PC = 2'd3    // program counter, fetches
    } ea_sel_e;

    // access size as requested by microcode
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0, // one beat, one lane
        SZ_WORD = 2'd1, // one beat, both lanes
        SZ_LONG = 2'd2  // two beats, low half first
    } size_e;
    // 2'd3 unused, treated like a byte

    // long accesses need the second beat
    function automatic logic is_long(size_e sz);
        return sz == SZ_LONG;
    endfunction

    // byte accesses select or replicate lanes
    function automatic logic is_byte(size_e sz);
        return sz != SZ_WORD && sz != SZ_LONG;
    endfunction

endpackage

//--- mem_unit.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

// memory access unit top, 16-bit bus with 24-bit addresses
module mem_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    // microcode
    input  logic                        req,
    input  logic                        wr,
    input  mem_pkg::ea_sel_e            ea_sel,
    input  mem_pkg::size_e              size,
    input  logic                        da2ea,
    // register unit
    input  logic [`MEM_ADDR_W-1:0]      da,
    input  logic [`MEM_ADDR_W-1:0]      pc,
    input  logic [2*`MEM_DATA_W-1:0]    xsp,
    input  logic [2*`MEM_DATA_W-1:0]    md,
    // external bus
    input  logic [`MEM_DATA_W-1:0]      bus_dout,
    output logic [`MEM_ADDR_W-1:0]      bus_addr,
    output logic [`MEM_DATA_W-1:0]      bus_din,
    output logic                        bus_rd,
    output logic                        bus_wr,
    // results
    output logic [`MEM_ADDR_W-1:0]      ea,
    output logic [2*`MEM_DATA_W-1:0]    mdata,
    output logic                        busy
);

    logic start, beat, timer_run, beat_last, capture;

    mem_ctrl u_ctrl (
        .clk(clk), .rst(rst), .cen(cen),
        .req(req), .wr(wr), .size(size), .beat_last(beat_last),
        .start(start), .beat(beat), .timer_run(timer_run), .capture(capture),
        .bus_rd(bus_rd), .bus_wr(bus_wr), .busy(busy)
    );

    mem_wait_timer u_timer (
        .clk(clk), .rst(rst), .cen(cen),
        .timer_run(timer_run), .beat_last(beat_last)
    );

    mem_addr_gen u_addr (
        .clk(clk), .rst(rst), .cen(cen),
        .start(start), .beat(beat), .da2ea(da2ea), .ea_sel(ea_sel),
        .da(da), .pc(pc), .xsp(xsp),
        .ea(ea), .bus_addr(bus_addr)
    );

    mem_data_path u_data (
        .clk(clk), .rst(rst), .cen(cen),
        .start(start), .beat(beat), .capture(capture), .size(size),
        .addr_lsb(bus_addr[0]),     // byte lane select
        .md(md), .bus_dout(bus_dout),
        .bus_din(bus_din), .mdata(mdata)
    );

endmodule

//--- mem_unit_tb.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

module mem_unit_tb;

    localparam int W          = `MEM_WAIT_STATES;
    localparam int MAX_CYCLES = 2000;   // all tests together need well under 200

    logic                     clk, rst, cen, req, wr, da2ea;
    mem_pkg::ea_sel_e         ea_sel;
    mem_pkg::size_e           size;
    logic [`MEM_ADDR_W-1:0]   da, pc, bus_addr, ea;
    logic [2*`MEM_DATA_W-1:0] xsp, md, mdata;
    logic [`MEM_DATA_W-1:0]   bus_dout, bus_din;
    logic                     bus_rd, bus_wr, busy;

    logic [15:0] mem [0:65535];         // word memory, bus_addr[16:1]
    int          wr_cnt;                // cycles into current write beat
    int          cycle_cnt;
    logic [31:0] lfsr;
    string       test_name;
    logic [23:0] seen_addr;             // bus_addr in first cycle of access
    logic [15:0] seen_din;

    tb_clock clk_gen (.clk(clk), .rst(rst));

    mem_unit dut0 (
        .clk(clk), .rst(rst), .cen(cen), .req(req), .wr(wr), .ea_sel(ea_sel),
        .size(size), .da2ea(da2ea), .da(da), .pc(pc), .xsp(xsp), .md(md),
        .bus_dout(bus_dout), .bus_addr(bus_addr), .bus_din(bus_din),
        .bus_rd(bus_rd), .bus_wr(bus_wr), .ea(ea), .mdata(mdata), .busy(busy)
    );

    // every bit of the word address shows up in the data
    function automatic logic [15:0] fill_word(input logic [15:0] i);
        return {i[7:0], i[15:8]} ^ 16'ha55a;
    endfunction

    function automatic logic [15:0] word_at(input logic [23:0] a);
        return fill_word(a[16:1]);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    assign bus_dout = bus_rd ? mem[bus_addr[16:1]] : '0;   // no read latency

    // memory takes the write at the last cycle of each beat
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_cnt <= 0;
            for (int i = 0; i < 65536; i++) mem[i] <= fill_word(16'(i));
        end else if (cen) begin
            if (bus_wr && wr_cnt == W) begin
                mem[bus_addr[16:1]] <= bus_din;
                wr_cnt <= 0;
            end else if (bus_wr) begin
                wr_cnt <= wr_cnt + 1;
            end else begin
                wr_cnt <= 0;
            end
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= MAX_CYCLES) begin
                $display("timeout: the run went past %0d cycles", MAX_CYCLES);
                $display("test failed");
                $fatal(1, "run did not finish");
            end
        end
    end

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // issue one access, count the cycles busy is seen high
    // stall_len: cen low after the first busy cycle, poke: req held high while busy
    task automatic run_access(input logic w, input mem_pkg::ea_sel_e sel,
                              input mem_pkg::size_e sz, input int stall_len,
                              input bit poke, output int cycles);
        @(negedge clk);
        req    = 1'b1;
        wr     = w;
        ea_sel = sel;
        size   = sz;
        @(negedge clk);
        req       = 1'b0;
        cycles    = 0;
        seen_addr = bus_addr;
        seen_din  = bus_din;
        while (busy) begin
            cycles++;
            check_value("bus_rd", 32'(!w), 32'(bus_rd));  // strobe tracks busy
            check_value("bus_wr", 32'(w), 32'(bus_wr));
            cen = (cycles > stall_len);
            req = poke;                                    // up to the last busy edge
            if (poke) wr = !w;                             // would be a write
            @(negedge clk);
        end
        cen = 1'b1;
        req = 1'b0;
        check_value("bus_rd idle", 32'h0, 32'(bus_rd));
        check_value("bus_wr idle", 32'h0, 32'(bus_wr));
    endtask

    task automatic test_reset;
        test_name = "reset";
        check_value("busy", 32'h0, 32'(busy));
        check_value("bus_rd", 32'h0, 32'(bus_rd));
        check_value("bus_wr", 32'h0, 32'(bus_wr));
        check_value("bus_addr", 32'h0, 32'(bus_addr));
        check_value("bus_din", 32'h0, 32'(bus_din));
        check_value("ea", 32'h0, 32'(ea));
        check_value("mdata", 32'h0, mdata);
    endtask

    task automatic test_word_read;
        int n;
        test_name = "word_read";
        da = 24'h01_2346;
        run_access(1'b0, mem_pkg::EA_DA, mem_pkg::SZ_WORD, 0, 1'b0, n);
        check_value("cycles da", 32'(W + 1), 32'(n));
        check_value("bus_addr da", 32'(da), 32'(seen_addr));
        check_value("mdata da", {16'h0, word_at(da)}, mdata);
        pc = 24'h00_0a10;                 // fetch
        run_access(1'b0, mem_pkg::EA_PC, mem_pkg::SZ_WORD, 0, 1'b0, n);
        check_value("cycles pc", 32'(W + 1), 32'(n));
        check_value("bus_addr pc", 32'(pc), 32'(seen_addr));
        check_value("mdata pc", {16'h0, word_at(pc)}, mdata);
    endtask

    task automatic test_long_write;
        int          n;
        logic [31:0] v;
        test_name = "long_write";
        random_bits(32, v);
        md  = v;
        xsp = 32'hff00_7ff0;              // top byte not part of the address
        run_access(1'b1, mem_pkg::EA_SP, mem_pkg::SZ_LONG, 0, 1'b0, n);
        check_value("cycles", 32'(2 * (W + 1)), 32'(n));
        check_value("bus_addr", 32'h0000_7ff0, 32'(seen_addr));
        check_value("mem low", 32'(md[15:0]), 32'(mem[16'h3ff8]));
        check_value("mem high", 32'(md[31:16]), 32'(mem[16'h3ff9]));
    endtask

    task automatic test_byte;
        int          n;
        logic [31:0] v;
        logic [15:0] word;
        test_name = "byte";
        da = 24'h00_1234;
        run_access(1'b0, mem_pkg::EA_DA, mem_pkg::SZ_BYTE, 0, 1'b0, n);
        word = word_at(da);
        check_value("even byte", {24'h0, word[7:0]}, mdata);
        da = 24'h00_1235;                 // same word, high lane
        run_access(1'b0, mem_pkg::EA_DA, mem_pkg::SZ_BYTE, 0, 1'b0, n);
        word = word_at(da);
        check_value("odd byte", {24'h0, word[15:8]}, mdata);
        random_bits(32, v);
        md = v;
        da = 24'h00_2001;
        run_access(1'b1, mem_pkg::EA_DA, mem_pkg::SZ_BYTE, 0, 1'b0, n);
        check_value("bus_din lanes", 32'({2{v[7:0]}}), 32'(seen_din));
        check_value("cycles", 32'(W + 1), 32'(n));
    endtask

    task automatic test_effective_addr;
        int          n;
        logic [23:0] a;
        test_name = "effective_addr";
        a = 24'h03_4560;
        @(negedge clk);
        da    = a;
        da2ea = 1'b1;
        @(negedge clk);
        da2ea = 1'b0;
        da    = 24'h00_0100;              // ea must keep the old da
        @(negedge clk);
        check_value("ea", 32'(a), 32'(ea));
        run_access(1'b0, mem_pkg::EA_EA, mem_pkg::SZ_LONG, 0, 1'b1, n);
        check_value("cycles", 32'(2 * (W + 1)), 32'(n));
        check_value("bus_addr", 32'(a), 32'(seen_addr));
        check_value("mdata", {word_at(a + 24'd2), word_at(a)}, mdata);
        @(negedge clk);
        check_value("busy after", 32'h0, 32'(busy));   // stray req dropped
    endtask

    task automatic test_clock_enable;
        int n;
        test_name = "clock_enable";
        da = 24'h00_0820;
        run_access(1'b0, mem_pkg::EA_DA, mem_pkg::SZ_WORD, 3, 1'b0, n);
        check_value("cycles", 32'(W + 1 + 3), 32'(n));
        check_value("mdata", {16'h0, word_at(da)}, mdata);
    endtask

    initial begin
        cen    = 1'b1;
        req    = 1'b0;
        wr     = 1'b0;
        da2ea  = 1'b0;
        ea_sel = mem_pkg::EA_DA;
        size   = mem_pkg::SZ_WORD;
        da     = '0;
        pc     = '0;
        xsp    = '0;
        md     = '0;
        lfsr   = 32'h1a09_9dc3;
        @(negedge rst);
        test_reset;
        test_word_read;
        test_long_write;
        test_byte;
        test_effective_addr;
        test_clock_enable;
        $display("test passed");
        $finish;
    end

endmodule

//--- mem_wait_timer.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

// counts the wait states of a bus beat
// beat_last marks the final cycle, beat restarts from zero after it
module mem_wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic timer_run,     // high for every cycle of an access
    output logic beat_last
);

    localparam logic [2:0] WAIT_LAST = 3'(`MEM_WAIT_STATES);

    logic [2:0] cnt;            // cycles spent in current beat

    // combinational, so the controller steps on the same edge
    assign beat_last = timer_run && cnt == WAIT_LAST;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen) begin
            if (!timer_run || beat_last) begin
                cnt <= '0;      // idle or beat boundary
            end else begin
                cnt <= cnt + 3'd1;
            end
        end
    end

endmodule

//--- project.f
+incdir+.
mem_pkg.sv
bus_pkg.sv
mem_ctrl.sv
mem_wait_timer.sv
mem_addr_gen.sv
mem_data_path.sv
mem_unit.sv
tb_clock.sv
mem_unit_tb.sv

//--- tb_clock.sv
`timescale 1ns/100ps

// free running clock and power-on reset for the testbench
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(negedge clk);  // 4 full cycles
        rst = 1'b0;
    end

endmodule
